/* exec_trace.txt */
// lane opcode funct shamt imm rs_data rt_data rt rd
// then expected wr_en wr_addr wr_data branch_taken, last line lane ff ends the trace
0 00 21 00 0000 00000005 00000007 02 03 1 03 0000000c 0
1 00 23 00 0000 00000003 00000005 02 04 1 04 fffffffe 0
0 00 24 00 0000 ff00ff00 0f0f0f0f 02 05 1 05 0f000f00 0
1 00 25 00 0000 ff00ff00 0f0f0f0f 02 06 1 06 ff0fff0f 0
0 00 26 00 0000 ff00ff00 0f0f0f0f 02 07 1 07 f00ff00f 0
1 00 27 00 0000 ff00ff00 0f0f0f0f 02 08 1 08 00f000f0 0
0 09 00 00 fffe 00000010 00000000 09 00 1 09 0000000e 0
1 0c 00 00 8001 ffffffff 00000000 0a 00 1 0a 00008001 0
0 0d 00 00 8000 00000001 00000000 0b 00 1 0b 00008001 0
1 0e 00 00 ffff ffff0000 00000000 0c 00 1 0c ffffffff 0
0 00 00 04 0000 12345678 0000000f 02 0d 1 0d 000000f0 0
1 00 03 08 0000 00000000 80000000 02 0e 1 0e ff800000 0
0 00 02 1f 0000 00000000 80000000 02 0f 1 0f 00000001 0
1 00 04 00 0000 00000024 00000003 02 10 1 10 00000030 0
0 00 07 00 0000 ffffffe1 f0000000 02 11 1 11 f8000000 0
1 00 06 00 0000 00000023 80000000 02 12 1 12 10000000 0
0 00 2a 00 0000 ffffffff 00000001 02 13 1 13 00000001 0
1 00 2b 00 0000 ffffffff 00000001 02 14 1 14 00000000 0
0 0a 00 00 ffff fffffffe 00000000 15 00 1 15 00000001 0
1 0b 00 00 ffff 00000005 00000000 16 00 1 16 00000001 0
0 0f 00 00 8000 00000000 00000000 17 00 1 17 80000000 0
1 00 21 00 0000 00000001 00000001 02 00 0 00 00000002 0
0 3f 00 00 0000 00000001 00000001 05 00 0 00 00000000 0
1 04 00 00 0000 0000abcd 0000abcd 00 00 0 00 00000000 1
0 05 00 00 0000 0000abcd 0000abcd 00 00 0 00 00000000 0
1 04 00 00 0000 00000001 00000002 00 00 0 00 00000000 0
0 05 00 00 0000 00000001 00000002 00 00 0 00 00000000 1
0 0d 00 00 00ff 00000000 00000000 1f 00 1 1f 000000ff 0
ff 00 00 00 0000 00000000 00000000 00 00 0 00 00000000 0

/* all.f */
mips_exec_pkg.sv
exec_dispatch.sv
alu.sv
exec_writeback.sv
mips_exec_top.sv
tb_mips_exec.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert --timescale 1ns/1ns \
      -f all.f --top-module tb_mips_exec \
   && ./obj_dir/Vtb_mips_exec \
   || { echo "simulation failed"; exit 1; }

/* tb_mips_exec.sv */
`timescale 1ns/1ns

module tb_mips_exec
   import mips_exec_pkg::*;
();

   localparam int NUM_LANES  = 2;
   localparam int FIELDS     = 13;            // Words per trace record
   localparam int MAX_REC    = 64;
   localparam int RST_CYCLES = 4;
   localparam int LATENCY    = 3;             // Drive to visible output
   localparam int DRAIN      = 4;             // Idle cycles watched at the end
   localparam int SLACK      = 20;
   localparam logic [31:0] END_MARK = 32'h0000_00ff;

   // Trace columns
   localparam int F_LANE = 0;
   localparam int F_OPC  = 1;
   localparam int F_FN   = 2;
   localparam int F_SH   = 3;
   localparam int F_IMM  = 4;
   localparam int F_RS   = 5;
   localparam int F_RT   = 6;
   localparam int F_RTN  = 7;
   localparam int F_RDN  = 8;
   localparam int F_EN   = 9;
   localparam int F_ADDR = 10;
   localparam int F_DATA = 11;
   localparam int F_BR   = 12;

   logic                            i_clk;
   logic                            i_rst;
   logic [NUM_LANES-1:0]            i_valid;
   logic [NUM_LANES*OPC_W-1:0]      i_opcode;
   logic [NUM_LANES*FUNCT_W-1:0]    i_funct;
   logic [NUM_LANES*SHAMT_W-1:0]    i_shamt;
   logic [NUM_LANES*IMM_W-1:0]      i_imm;
   logic [NUM_LANES*DATA_W-1:0]     i_rs_data;
   logic [NUM_LANES*DATA_W-1:0]     i_rt_data;
   logic [NUM_LANES*REG_ADDR_W-1:0] i_rt;
   logic [NUM_LANES*REG_ADDR_W-1:0] i_rd;
   logic [NUM_LANES-1:0]            o_valid;
   logic [NUM_LANES-1:0]            o_wr_en;
   logic [NUM_LANES*REG_ADDR_W-1:0] o_wr_addr;
   logic [NUM_LANES*DATA_W-1:0]     o_wr_data;
   logic [NUM_LANES-1:0]            o_branch_taken;

   logic [31:0] trace_mem [0:MAX_REC*FIELDS-1];
   int          n_rec;
   int          run_limit = 0;                // Set once the trace is loaded
   int          cycle     = 0;                // Rising edges since start
   int          due [0:MAX_REC-1];            // Cycle each result is expected
   int          pend_q [NUM_LANES][$];        // Issued records per lane in order

   mips_exec_top #(
      .NUM_LANES      (NUM_LANES)
   ) i_mips_exec_top (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_valid        (i_valid),
      .i_opcode       (i_opcode),
      .i_funct        (i_funct),
      .i_shamt        (i_shamt),
      .i_imm          (i_imm),
      .i_rs_data      (i_rs_data),
      .i_rt_data      (i_rt_data),
      .i_rt           (i_rt),
      .i_rd           (i_rd),
      .o_valid        (o_valid),
      .o_wr_en        (o_wr_en),
      .o_wr_addr      (o_wr_addr),
      .o_wr_data      (o_wr_data),
      .o_branch_taken (o_branch_taken)
   );

   always #5 i_clk = ~i_clk;                  // 10 ns period

   always @(posedge i_clk)
   begin
      cycle <= cycle + 1;
      if (run_limit > 0 && cycle > RST_CYCLES + run_limit)
         abort_run("timeout, results never arrived");
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("SOME TESTS FAILED");
      $fatal(1, "%s", why);
   endtask

   function automatic logic [31:0] trace_field(input int r, input int f);
      return trace_mem[r*FIELDS + f];
   endfunction

   function automatic int outstanding();
      int n;
      n = 0;
      for (int k = 0; k < NUM_LANES; k++)
         n += pend_q[k].size();
      return n;
   endfunction

   task automatic check_cycle(input int lane, input int got, input int exp);
      if (got != exp)
      begin
         $display("[ERROR] %0t: lane %0d result at cycle %0d, expected cycle %0d",
                  $time, lane, got, exp);
         abort_run("result latency mismatch");
      end
   endtask

   // Address and data only matter when a write is expected
   task automatic check_write(input int lane, input logic got_en,
                              input logic [REG_ADDR_W-1:0] got_addr,
                              input logic [DATA_W-1:0] got_data, input logic exp_en,
                              input logic [REG_ADDR_W-1:0] exp_addr,
                              input logic [DATA_W-1:0] exp_data);
      if (got_en !== exp_en || (exp_en && (got_addr !== exp_addr || got_data !== exp_data)))
      begin
         $display("[ERROR] %0t: lane %0d write en=%0b addr=%0d data=%h, expected %0b %0d %h",
                  $time, lane, got_en, got_addr, got_data, exp_en, exp_addr, exp_data);
         abort_run("register write mismatch");
      end
   endtask

   task automatic check_branch(input int lane, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: lane %0d branch_taken=%0b, expected %0b",
                  $time, lane, got, exp);
         abort_run("branch flag mismatch");
      end
   endtask

   task automatic drive_record(input int r);
      int lane;
      lane = int'(trace_field(r, F_LANE));
      i_valid[lane]                              = 1'b1;
      i_opcode[lane*OPC_W +: OPC_W]              = OPC_W'(trace_field(r, F_OPC));
      i_funct[lane*FUNCT_W +: FUNCT_W]           = FUNCT_W'(trace_field(r, F_FN));
      i_shamt[lane*SHAMT_W +: SHAMT_W]           = SHAMT_W'(trace_field(r, F_SH));
      i_imm[lane*IMM_W +: IMM_W]                 = IMM_W'(trace_field(r, F_IMM));
      i_rs_data[lane*DATA_W +: DATA_W]           = trace_field(r, F_RS);
      i_rt_data[lane*DATA_W +: DATA_W]           = trace_field(r, F_RT);
      i_rt[lane*REG_ADDR_W +: REG_ADDR_W]        = REG_ADDR_W'(trace_field(r, F_RTN));
      i_rd[lane*REG_ADDR_W +: REG_ADDR_W]        = REG_ADDR_W'(trace_field(r, F_RDN));
      due[r] = cycle + LATENCY;                                // Fixed pipeline depth
      pend_q[lane].push_back(r);
   endtask

   // Sampled on the falling edge away from register updates
   task automatic watch_outputs();
      int r;
      for (int k = 0; k < NUM_LANES; k++)
      begin
         if (o_valid[k] === 1'b1)
         begin
            if (pend_q[k].size() == 0)
               abort_run($sformatf("lane %0d gave a result that was never issued", k));
            else
            begin
               r = pend_q[k].pop_front();
               check_cycle(k, cycle, due[r]);
               check_write(k, o_wr_en[k], o_wr_addr[k*REG_ADDR_W +: REG_ADDR_W],
                           o_wr_data[k*DATA_W +: DATA_W], 1'(trace_field(r, F_EN)),
                           REG_ADDR_W'(trace_field(r, F_ADDR)), trace_field(r, F_DATA));
               check_branch(k, o_branch_taken[k], 1'(trace_field(r, F_BR)));
            end
         end
         else if (o_valid[k] !== 1'b0 || o_wr_en[k] !== 1'b0 || o_branch_taken[k] !== 1'b0)
            abort_run($sformatf("lane %0d has a valid, write or branch flag not low", k));
         else if (pend_q[k].size() != 0 && due[pend_q[k][0]] <= cycle)
            abort_run($sformatf("lane %0d missed a result that was due", k));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      int                   rec;
      int                   lane;
      logic [NUM_LANES-1:0] used;
      i_clk     = 1'b0;
      i_rst     = 1'b1;
      i_valid   = '1;                         // Strobes in reset must be ignored
      i_opcode  = '0;
      i_funct   = '0;
      i_shamt   = '0;
      i_imm     = '0;
      i_rs_data = '0;
      i_rt_data = '0;
      i_rt      = '0;
      i_rd      = '0;
      $readmemh("exec_trace.txt", trace_mem);
      n_rec = 0;
      while (n_rec < MAX_REC && trace_mem[n_rec*FIELDS] !== END_MARK)
         n_rec++;
      if (n_rec == 0 || n_rec == MAX_REC)
         abort_run("trace file missing, empty or without end marker");
      for (int r = 0; r < n_rec; r++)
         if (trace_field(r, F_LANE) >= NUM_LANES)
            abort_run($sformatf("trace record %0d names a lane that does not exist", r));
      run_limit = n_rec + LATENCY + SLACK;

      repeat (RST_CYCLES)                     // Outputs stay quiet in reset
      begin
         @(negedge i_clk);
         watch_outputs();
      end
      i_rst   = 1'b0;
      i_valid = '0;

      // Records fill one cycle until a lane repeats
      rec = 0;
      while (rec < n_rec || outstanding() != 0)
      begin
         @(negedge i_clk);
         watch_outputs();
         i_valid = '0;
         used    = '0;
         while (rec < n_rec && !used[int'(trace_field(rec, F_LANE))])
         begin
            lane       = int'(trace_field(rec, F_LANE));
            used[lane] = 1'b1;
            drive_record(rec);
            rec++;
         end
      end

      repeat (DRAIN)                          // Nothing extra may appear
      begin
         @(negedge i_clk);
         watch_outputs();
      end
      if (outstanding() != 0)
         abort_run("results still outstanding at end of run");
      else
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

/* mips_exec_top.sv */
`timescale 1ns/1ns

module mips_exec_top
   import mips_exec_pkg::*;
#(
   parameter int NUM_LANES = 2,
   parameter int DATA_W    = mips_exec_pkg::DATA_W
)
(
   input  logic                            i_clk,
   input  logic                            i_rst,
   input  logic [NUM_LANES-1:0]            i_valid,
   input  logic [NUM_LANES*OPC_W-1:0]      i_opcode,
   input  logic [NUM_LANES*FUNCT_W-1:0]    i_funct,
   input  logic [NUM_LANES*SHAMT_W-1:0]    i_shamt,
   input  logic [NUM_LANES*IMM_W-1:0]      i_imm,
   input  logic [NUM_LANES*DATA_W-1:0]     i_rs_data,
   input  logic [NUM_LANES*DATA_W-1:0]     i_rt_data,
   input  logic [NUM_LANES*REG_ADDR_W-1:0] i_rt,
   input  logic [NUM_LANES*REG_ADDR_W-1:0] i_rd,
   output logic [NUM_LANES-1:0]            o_valid,
   output logic [NUM_LANES-1:0]            o_wr_en,
   output logic [NUM_LANES*REG_ADDR_W-1:0] o_wr_addr,
   output logic [NUM_LANES*DATA_W-1:0]     o_wr_data,
   output logic [NUM_LANES-1:0]            o_branch_taken
);

   // Dispatch to ALU lanes
   logic [NUM_LANES-1:0]            d_valid;
   logic [NUM_LANES*ALU_OP_W-1:0]   d_op;
   logic [NUM_LANES*DATA_W-1:0]     d_a;
   logic [NUM_LANES*DATA_W-1:0]     d_b;
   logic [NUM_LANES*WB_KIND_W-1:0]  d_kind;
   logic [NUM_LANES*REG_ADDR_W-1:0] d_dst;

   // ALU lanes to writeback
   logic [NUM_LANES-1:0]            x_valid;
   logic [NUM_LANES*DATA_W-1:0]     x_result;
   logic [NUM_LANES-1:0]            x_zero;
   logic [NUM_LANES*WB_KIND_W-1:0]  x_kind;
   logic [NUM_LANES*REG_ADDR_W-1:0] x_dst;

   exec_dispatch #(
      .NUM_LANES (NUM_LANES),
      .DATA_W    (DATA_W)
   ) i_exec_dispatch (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_valid   (i_valid),
      .i_opcode  (i_opcode),
      .i_funct   (i_funct),
      .i_shamt   (i_shamt),
      .i_imm     (i_imm),
      .i_rs_data (i_rs_data),
      .i_rt_data (i_rt_data),
      .i_rt      (i_rt),
      .i_rd      (i_rd),
      .o_valid   (d_valid),
      .o_op      (d_op),
      .o_a       (d_a),
      .o_b       (d_b),
      .o_kind    (d_kind),
      .o_dst     (d_dst)
   );

   ////////////////////////////////////////////////////////////
   // One ALU per lane
   ////////////////////////////////////////////////////////////

   for (genvar k = 0; k < NUM_LANES; k++)
   begin : gen_lane
      alu #(
         .DATA_W   (DATA_W)
      ) i_alu (
         .i_clk    (i_clk),
         .i_rst    (i_rst),
         .i_valid  (d_valid[k]),
         .i_op     (d_op[k*ALU_OP_W +: ALU_OP_W]),
         .i_a      (d_a[k*DATA_W +: DATA_W]),
         .i_b      (d_b[k*DATA_W +: DATA_W]),
         .i_kind   (d_kind[k*WB_KIND_W +: WB_KIND_W]),
         .i_dst    (d_dst[k*REG_ADDR_W +: REG_ADDR_W]),
         .o_valid  (x_valid[k]),
         .o_result (x_result[k*DATA_W +: DATA_W]),
         .o_zero   (x_zero[k]),
         .o_kind   (x_kind[k*WB_KIND_W +: WB_KIND_W]),
         .o_dst    (x_dst[k*REG_ADDR_W +: REG_ADDR_W])
      );
   end

   exec_writeback #(
      .NUM_LANES      (NUM_LANES),
      .DATA_W         (DATA_W)
   ) i_exec_writeback (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_valid        (x_valid),
      .i_result       (x_result),
      .i_zero         (x_zero),
      .i_kind         (x_kind),
      .i_dst          (x_dst),
      .o_valid        (o_valid),
      .o_wr_en        (o_wr_en),
      .o_wr_addr      (o_wr_addr),
      .o_wr_data      (o_wr_data),
      .o_branch_taken (o_branch_taken)
   );

endmodule

/* exec_writeback.sv */
`timescale 1ns/1ns

module exec_writeback
   import mips_exec_pkg::*;
#(
   parameter int NUM_LANES = 2,
   parameter int DATA_W    = mips_exec_pkg::DATA_W
)
(
   input  logic                            i_clk,
   input  logic                            i_rst,
   input  logic [NUM_LANES-1:0]            i_valid,
   input  logic [NUM_LANES*DATA_W-1:0]     i_result,
   input  logic [NUM_LANES-1:0]            i_zero,
   input  logic [NUM_LANES*WB_KIND_W-1:0]  i_kind,
   input  logic [NUM_LANES*REG_ADDR_W-1:0] i_dst,
   output logic [NUM_LANES-1:0]            o_valid,
   output logic [NUM_LANES-1:0]            o_wr_en,
   output logic [NUM_LANES*REG_ADDR_W-1:0] o_wr_addr,
   output logic [NUM_LANES*DATA_W-1:0]     o_wr_data,
   output logic [NUM_LANES-1:0]            o_branch_taken
);

   for (genvar k = 0; k < NUM_LANES; k++)
   begin : gen_wb
      wb_kind_e              kind;
      logic [REG_ADDR_W-1:0] dst;
      logic                  wr_c;
      logic                  br_c;
      logic                  valid_q;
      logic                  wr_q;
      logic                  br_q;
      logic [REG_ADDR_W-1:0] addr_q;
      logic [DATA_W-1:0]     data_q;

      assign kind = wb_kind_e'(i_kind[k*WB_KIND_W +: WB_KIND_W]);
      assign dst  = i_dst[k*REG_ADDR_W +: REG_ADDR_W];

      // $zero is hardwired so writes to it are dropped
      assign wr_c = i_valid[k] && (kind == WB_REG) && (dst != '0);

      // Branch compare was a SUB so zero means equal
      assign br_c = i_valid[k] && (((kind == WB_BEQ) &&  i_zero[k]) ||
                                   ((kind == WB_BNE) && !i_zero[k]));

      always_ff @(posedge i_clk)
      begin
         if (i_rst)
         begin
            valid_q <= 1'b0;
            wr_q    <= 1'b0;
            br_q    <= 1'b0;
         end
         else
         begin
            valid_q <= i_valid[k];
            wr_q    <= wr_c;
            br_q    <= br_c;
         end
      end

      always_ff @(posedge i_clk)
      begin
         if (i_valid[k])
         begin
            addr_q <= dst;
            data_q <= i_result[k*DATA_W +: DATA_W];
         end
      end

      assign o_valid[k]                            = valid_q;
      assign o_wr_en[k]                            = wr_q;
      assign o_branch_taken[k]                     = br_q;
      assign o_wr_addr[k*REG_ADDR_W +: REG_ADDR_W] = addr_q;
      assign o_wr_data[k*DATA_W +: DATA_W]         = data_q;

      // Branch resolve trusts the zero flag that arrives with the result
      a_zero_in: assert property (@(posedge i_clk) disable iff (i_rst)
         i_valid[k] |-> (i_zero[k] == (i_result[k*DATA_W +: DATA_W] == '0)))
         else $error("lane %0d: zero flag disagrees with result", k);
   end

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu
   import mips_exec_pkg::*;
#(
   parameter int DATA_W = mips_exec_pkg::DATA_W
)
(
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_valid,
   input  logic [ALU_OP_W-1:0]   i_op,
   input  logic [DATA_W-1:0]     i_a,
   input  logic [DATA_W-1:0]     i_b,
   input  logic [WB_KIND_W-1:0]  i_kind,
   input  logic [REG_ADDR_W-1:0] i_dst,
   output logic                  o_valid,
   output logic [DATA_W-1:0]     o_result,
   output logic                  o_zero,
   output logic [WB_KIND_W-1:0]  o_kind,
   output logic [REG_ADDR_W-1:0] o_dst
);

   alu_op_e              op;
   logic [SHAMT_W-1:0]   sh;       // Only low bits of B shift
   logic [DATA_W-1:0]    result_c;

   assign op = alu_op_e'(i_op);
   assign sh = i_b[SHAMT_W-1:0];

   ////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      case (op)
         ALU_SLL:  result_c = i_a << sh;                           // SLL, SLLV
         ALU_SRL:  result_c = i_a >> sh;                           // SRL, SRLV
         ALU_SRA:  result_c = DATA_W'($signed(i_a) >>> sh);        // Sign fill
         ALU_ADD:  result_c = i_a + i_b;                           // ADDU, ADDIU
         ALU_SUB:  result_c = i_a - i_b;                           // SUBU, branches
         ALU_AND:  result_c = i_a & i_b;
         ALU_OR:   result_c = i_a | i_b;
         ALU_XOR:  result_c = i_a ^ i_b;
         ALU_NOR:  result_c = ~(i_a | i_b);
         ALU_SLT:  result_c = {{(DATA_W-1){1'b0}}, $signed(i_a) < $signed(i_b)};
         ALU_SLTU: result_c = {{(DATA_W-1){1'b0}}, i_a < i_b};
         ALU_LUI:  result_c = i_b << IMM_W;                        // Imm to upper half
         default:  result_c = i_a + i_b;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk)
   begin
      if (i_rst)
         o_valid <= 1'b0;
      else
         o_valid <= i_valid;
   end

   // Kind and dst ride along with the result
   always_ff @(posedge i_clk)
   begin
      if (i_valid)
      begin
         o_result <= result_c;
         o_zero   <= (result_c == '0);   // Feeds branch resolve
         o_kind   <= i_kind;
         o_dst    <= i_dst;
      end
   end

   // Branches read zero after SUB as equal operands
   a_zero_flag: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_valid && op == ALU_SUB) |=> (o_zero == ($past(i_a) == $past(i_b))))
      else $error("zero flag after SUB disagrees with operand compare");

endmodule

/* exec_dispatch.sv */
`timescale 1ns/1ns

module exec_dispatch
   import mips_exec_pkg::*;
#(
   parameter int NUM_LANES = 2,
   parameter int DATA_W    = mips_exec_pkg::DATA_W
)
(
   input  logic                            i_clk,
   input  logic                            i_rst,
   input  logic [NUM_LANES-1:0]            i_valid,
   input  logic [NUM_LANES*OPC_W-1:0]      i_opcode,
   input  logic [NUM_LANES*FUNCT_W-1:0]    i_funct,
   input  logic [NUM_LANES*SHAMT_W-1:0]    i_shamt,
   input  logic [NUM_LANES*IMM_W-1:0]      i_imm,
   input  logic [NUM_LANES*DATA_W-1:0]     i_rs_data,
   input  logic [NUM_LANES*DATA_W-1:0]     i_rt_data,
   input  logic [NUM_LANES*REG_ADDR_W-1:0] i_rt,
   input  logic [NUM_LANES*REG_ADDR_W-1:0] i_rd,
   output logic [NUM_LANES-1:0]            o_valid,
   output logic [NUM_LANES*ALU_OP_W-1:0]   o_op,
   output logic [NUM_LANES*DATA_W-1:0]     o_a,
   output logic [NUM_LANES*DATA_W-1:0]     o_b,
   output logic [NUM_LANES*WB_KIND_W-1:0]  o_kind,
   output logic [NUM_LANES*REG_ADDR_W-1:0] o_dst
);

   for (genvar k = 0; k < NUM_LANES; k++)
   begin : gen_dec
      opcode_e               opc;
      funct_e                fn;
      logic [DATA_W-1:0]     rs_val;
      logic [DATA_W-1:0]     rt_val;
      logic [IMM_W-1:0]      imm;
      logic [DATA_W-1:0]     simm;     // Sign-extended imm
      logic [DATA_W-1:0]     zimm;     // Zero-extended imm
      logic [DATA_W-1:0]     sh_b;     // shamt as operand B
      alu_op_e               op_c;
      wb_kind_e              kind_c;
      logic [DATA_W-1:0]     a_c;
      logic [DATA_W-1:0]     b_c;
      logic [REG_ADDR_W-1:0] dst_c;
      logic                  valid_q;
      alu_op_e               op_q;
      wb_kind_e              kind_q;
      logic [DATA_W-1:0]     a_q;
      logic [DATA_W-1:0]     b_q;
      logic [REG_ADDR_W-1:0] dst_q;

      assign opc    = opcode_e'(i_opcode[k*OPC_W +: OPC_W]);
      assign fn     = funct_e'(i_funct[k*FUNCT_W +: FUNCT_W]);
      assign rs_val = i_rs_data[k*DATA_W +: DATA_W];
      assign rt_val = i_rt_data[k*DATA_W +: DATA_W];
      assign imm    = i_imm[k*IMM_W +: IMM_W];
      assign simm   = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
      assign zimm   = {{(DATA_W-IMM_W){1'b0}}, imm};
      assign sh_b   = {{(DATA_W-SHAMT_W){1'b0}}, i_shamt[k*SHAMT_W +: SHAMT_W]};

      ////////////////////////////////////////////////////////////
      // Decode
      ////////////////////////////////////////////////////////////

      always_comb
      begin
         op_c   = ALU_ADD;                             // Plain add unless decoded
         kind_c = WB_NONE;
         a_c    = rs_val;
         b_c    = rt_val;
         dst_c  = i_rt[k*REG_ADDR_W +: REG_ADDR_W];   // I-type writes rt
         case (opc)
            OP_RTYPE:
            begin
               kind_c = WB_REG;
               dst_c  = i_rd[k*REG_ADDR_W +: REG_ADDR_W];
               case (fn)
                  FN_SLL:  begin op_c = ALU_SLL; a_c = rt_val; b_c = sh_b;   end
                  FN_SRL:  begin op_c = ALU_SRL; a_c = rt_val; b_c = sh_b;   end
                  FN_SRA:  begin op_c = ALU_SRA; a_c = rt_val; b_c = sh_b;   end
                  FN_SLLV: begin op_c = ALU_SLL; a_c = rt_val; b_c = rs_val; end
                  FN_SRLV: begin op_c = ALU_SRL; a_c = rt_val; b_c = rs_val; end
                  FN_SRAV: begin op_c = ALU_SRA; a_c = rt_val; b_c = rs_val; end
                  FN_ADDU: op_c = ALU_ADD;
                  FN_SUBU: op_c = ALU_SUB;
                  FN_AND:  op_c = ALU_AND;
                  FN_OR:   op_c = ALU_OR;
                  FN_XOR:  op_c = ALU_XOR;
                  FN_NOR:  op_c = ALU_NOR;
                  FN_SLT:  op_c = ALU_SLT;
                  FN_SLTU: op_c = ALU_SLTU;
                  default: kind_c = WB_NONE;          // Unknown funct has no effect
               endcase
            end
            OP_BEQ:   begin op_c = ALU_SUB;  kind_c = WB_BEQ;             end
            OP_BNE:   begin op_c = ALU_SUB;  kind_c = WB_BNE;             end
            OP_ADDIU: begin op_c = ALU_ADD;  kind_c = WB_REG; b_c = simm; end
            OP_SLTI:  begin op_c = ALU_SLT;  kind_c = WB_REG; b_c = simm; end
            OP_SLTIU: begin op_c = ALU_SLTU; kind_c = WB_REG; b_c = simm; end
            OP_ANDI:  begin op_c = ALU_AND;  kind_c = WB_REG; b_c = zimm; end
            OP_ORI:   begin op_c = ALU_OR;   kind_c = WB_REG; b_c = zimm; end
            OP_XORI:  begin op_c = ALU_XOR;  kind_c = WB_REG; b_c = zimm; end
            OP_LUI:   begin op_c = ALU_LUI;  kind_c = WB_REG; b_c = simm; end
            default:  kind_c = WB_NONE;                // Unknown opcode
         endcase
      end

      always_ff @(posedge i_clk)
      begin
         if (i_rst)
            valid_q <= 1'b0;
         else
            valid_q <= i_valid[k];
      end

      always_ff @(posedge i_clk)
      begin
         if (i_valid[k])                              // Hold payload when idle
         begin
            op_q   <= op_c;
            kind_q <= kind_c;
            a_q    <= a_c;
            b_q    <= b_c;
            dst_q  <= dst_c;
         end
      end

      assign o_valid[k]                              = valid_q;
      assign o_op[k*ALU_OP_W +: ALU_OP_W]            = op_q;
      assign o_kind[k*WB_KIND_W +: WB_KIND_W]        = kind_q;
      assign o_a[k*DATA_W +: DATA_W]                 = a_q;
      assign o_b[k*DATA_W +: DATA_W]                 = b_q;
      assign o_dst[k*REG_ADDR_W +: REG_ADDR_W]       = dst_q;

      // Decode needs fully known fields on a valid lane
      a_dec_known: assert property (@(posedge i_clk) disable iff (i_rst)
         i_valid[k] |-> !$isunknown({i_opcode[k*OPC_W +: OPC_W],
                                     i_funct[k*FUNCT_W +: FUNCT_W]}))
         else $error("lane %0d: opcode or funct has unknown bits", k);
   end

endmodule

/* mips_exec_pkg.sv */
package mips_exec_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   parameter int DATA_W     = 32;  // Register and ALU width
   parameter int REG_ADDR_W = 5;   // Register number
   parameter int OPC_W      = 6;   // Major opcode field
   parameter int FUNCT_W    = 6;   // R-type funct field
   parameter int SHAMT_W    = 5;   // Shift amount and low bits of B on shifts
   parameter int IMM_W      = 16;  // I-type immediate
   parameter int ALU_OP_W   = 4;   // ALU control code
   parameter int WB_KIND_W  = 2;   // Writeback action

   ////////////////////////////////////////////////////////////
   // Instruction encodings
   ////////////////////////////////////////////////////////////

   typedef enum logic [OPC_W-1:0] {
      OP_RTYPE = 6'h00,  // Look at funct
      OP_BEQ   = 6'h04,
      OP_BNE   = 6'h05,
      OP_ADDIU = 6'h09,  // Sign-extended imm
      OP_SLTI  = 6'h0a,
      OP_SLTIU = 6'h0b,  // Sign-extended imm compared unsigned
      OP_ANDI  = 6'h0c,  // Zero-extended imm
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f
   } opcode_e;

   typedef enum logic [FUNCT_W-1:0] {
      FN_SLL  = 6'h00,  // Shift by shamt
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_SLLV = 6'h04,  // Shift by rs
      FN_SRLV = 6'h06,
      FN_SRAV = 6'h07,
      FN_ADDU = 6'h21,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

   // Classic MIPS ALU control numbering
   typedef enum logic [ALU_OP_W-1:0] {
      ALU_AND  = 4'b0000,
      ALU_OR   = 4'b0001,
      ALU_ADD  = 4'b0010,
      ALU_SUB  = 4'b0110,  // Also BEQ/BNE compare
      ALU_SLT  = 4'b0111,  // Signed
      ALU_SLTU = 4'b1000,  // Unsigned
      ALU_XOR  = 4'b1001,
      ALU_NOR  = 4'b1010,
      ALU_SLL  = 4'b1011,
      ALU_SRL  = 4'b1100,
      ALU_SRA  = 4'b1101,
      ALU_LUI  = 4'b1110   // B into upper half
   } alu_op_e;

   typedef enum logic [WB_KIND_W-1:0] {
      WB_NONE = 2'd0,  // Drop result
      WB_REG  = 2'd1,  // Register write
      WB_BEQ  = 2'd2,  // Taken on zero
      WB_BNE  = 2'd3   // Taken on nonzero
   } wb_kind_e;

endpackage
